// ==== camConfigPkg.sv ====
`default_nettype none

package camConfigPkg;

	// ----------------------------------------------------------
	// Bus timing
	// ----------------------------------------------------------

	// System clock
	localparam int unsigned ClkFreqHz = 50_000_000;

	// SCCB bit rate
	localparam int unsigned SccbFreqHz = 100_000;

	// Four quarter ticks make one SCCB bit
	localparam int unsigned QuarterDiv = ClkFreqHz / (4 * SccbFreqHz);

	// Width of the quarter tick divider
	localparam int unsigned DivWidth = $clog2(QuarterDiv);

	// ----------------------------------------------------------
	// Register table
	// ----------------------------------------------------------

	// Entries sent after reset
	localparam int unsigned TableSize = 40;

	// Enough bits to count every entry
	localparam int unsigned IndexWidth = $clog2(TableSize);

	// Sensor write address on the SCCB bus
	localparam logic [7:0] DevWriteAddr = 8'h42;

	// One table word, address in the upper byte
	typedef struct packed {
		logic [7:0] regAddr;
		logic [7:0] regData;
	} regEntryT;

	typedef logic [IndexWidth-1:0] tableIndexT;

	// ----------------------------------------------------------
	// Write frame
	// ----------------------------------------------------------

	// Three bytes of one write, first one on the bus at the top
	typedef struct packed {
		logic [7:0] devAddr;
		logic [7:0] regAddr;
		logic [7:0] regData;
	} sccbFieldsT;

	// Built by field, shifted out by byte
	typedef union packed {
		sccbFieldsT       fields;
		logic [2:0][7:0]  bytes;
	} sccbFrameT;

endpackage

`default_nettype wire

// ==== camConfigSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module camConfigSequencer (
	input  logic                     iCLK,
	input  logic                     iRST_N,
	output camConfigPkg::tableIndexT entryIndex,
	input  camConfigPkg::regEntryT   entry,
	output camConfigPkg::sccbFrameT  frame,
	output logic                     go,
	input  logic                     done,
	output logic                     configDone
);

	import camConfigPkg::*;

	typedef enum logic [1:0] {
		StIssue,
		StWait,
		StAdvance,
		StFinished
	} seqStateT;

	seqStateT state;

	// Frame follows the current entry
	// index only moves together with go, so it holds for the whole write
	always_comb
	begin
		frame.fields.devAddr = DevWriteAddr;
		frame.fields.regAddr = entry.regAddr;
		frame.fields.regData = entry.regData;
	end

	// ----------------------------------------------------------
	// Table walk
	// ----------------------------------------------------------
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			state      <= StIssue;
			entryIndex <= '0;
			go         <= 1'b0;
			configDone <= 1'b0;
		end
		else
		begin
			// go is a single cycle pulse
			go <= 1'b0;
			case (state)
				// First write right after reset
				StIssue:
				begin
					go    <= 1'b1;
					state <= StWait;
				end
				StWait:
				begin
					if (done)
					begin
						if (entryIndex == tableIndexT'(TableSize - 1))
						begin
							configDone <= 1'b1;
							state      <= StFinished;
						end
						else
							state <= StAdvance;
					end
				end
				// Step and send the next entry together
				StAdvance:
				begin
					entryIndex <= entryIndex + 1'b1;
					go         <= 1'b1;
					state      <= StWait;
				end
				// Stays here until the next reset
				default:
					state <= StFinished;
			endcase
		end
	end

	// No second go before the write master answers
	goWhilePending: assert property (@(posedge iCLK) disable iff (!iRST_N)
		go |=> (!go until done));

	indexInRange: assert property (@(posedge iCLK) disable iff (!iRST_N)
		entryIndex <= tableIndexT'(TableSize - 1));

endmodule

`default_nettype wire

// ==== camConfigTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module camConfigTb;

	import camConfigPkg::*;

	// Bus timing as the SCCB framing fixes it
	localparam int QuarterCycles = 125;
	localparam int WriteCycles   = 120 * QuarterCycles + 1;
	localparam int WriteTimeout  = 2 * WriteCycles;
	localparam int DoneTimeout   = 2000;
	localparam int QuietCycles   = 2000;
	localparam int ResetCycles   = 16;
	// About halfway into a write
	localparam int MidWriteCycles = 7000;

	logic iCLK;
	logic iRST_N;
	logic resetReq;
	logic sioc;
	logic siodOut;
	logic siodOe;
	logic configDone;

	// Bookkeeping
	int errors;
	int checks;
	logic [15:0] expTable [40];

	// Monitor state
	sccbFieldsT writeQ [$];
	logic       prevSioc;
	logic       prevSda;
	logic       inFrame;
	logic       measuring;
	int         bitCnt;
	int         highCnt;
	int         startCount;
	int         stopCount;
	logic [23:0] frameBits;

	tbClockGen uClockGen (
		.resetReq (resetReq),
		.iCLK     (iCLK),
		.iRST_N   (iRST_N)
	);

	camConfigTop DUT (
		.iCLK       (iCLK),
		.iRST_N     (iRST_N),
		.sioc       (sioc),
		.siodOut    (siodOut),
		.siodOe     (siodOe),
		.configDone (configDone)
	);

	// ----------------------------------------------------------
	// Reporting
	// ----------------------------------------------------------
	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic reportError(input string msg);
		errors++;
		$display("Error: %s at %0t", msg, $time);
	endtask

	// ----------------------------------------------------------
	// SCCB bus monitor
	// ----------------------------------------------------------
	// Called once per falling iCLK edge, where the pins are stable
	task monitorBus();
		logic sda;
		// Released line reads high through the pull-up
		sda = siodOe ? siodOut : 1'b1;
		if (!iRST_N)
		begin
			inFrame   = 1'b0;
			measuring = 1'b0;
		end
		// Start, SIOD falls under a high SIOC
		else if (prevSioc && sioc && prevSda && !sda)
		begin
			startCount++;
			if (inFrame)
				reportError("start condition inside a write");
			inFrame   = 1'b1;
			measuring = 1'b0;
			bitCnt    = 0;
			frameBits = '0;
		end
		// Stop, SIOD rises under a high SIOC
		else if (prevSioc && sioc && !prevSda && sda)
		begin
			stopCount++;
			if (!inFrame || bitCnt != 27)
				reportError("SIOD rose while SIOC high before the 27th bit");
			else
				writeQ.push_back(sccbFieldsT'(frameBits));
			inFrame = 1'b0;
		end
		// Rising SIOC samples a bit
		else if (!prevSioc && sioc && inFrame && bitCnt < 27)
		begin
			// Ninth bit of each byte is don't care
			if (bitCnt % 9 != 8)
				frameBits = {frameBits[22:0], sda};
			bitCnt++;
			measuring = 1'b1;
			highCnt   = 1;
		end
		else if (prevSioc && !sioc)
		begin
			if (measuring)
				checkValue("siocHighCycles", highCnt, 2 * QuarterCycles);
			measuring = 1'b0;
		end
		else if (sioc && measuring)
			highCnt++;
		prevSioc = sioc;
		prevSda  = sda;
	endtask

	always @(negedge iCLK)
		monitorBus();

	// ----------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------
	task automatic expectBusIdle();
		checkValue("sioc", sioc, 1);
		checkValue("siodOe", siodOe, 0);
		checkValue("configDone", configDone, 0);
	endtask

	// Polled on the rising edge, the monitor pushes on the falling one
	task automatic waitWrite(output sccbFieldsT word, output bit ok);
		int cycles;
		ok     = 1'b0;
		word   = '0;
		cycles = 0;
		while (!ok && cycles < WriteTimeout)
		begin
			@(posedge iCLK);
			if (writeQ.size() > 0)
			begin
				word = writeQ.pop_front();
				ok   = 1'b1;
			end
			cycles++;
		end
		if (!ok)
			reportError("timeout waiting for an SCCB write");
	endtask

	task automatic compareWrite(input int idx, input sccbFieldsT word);
		checkValue($sformatf("devAddr[%0d]", idx), word.devAddr, 8'h42);
		checkValue($sformatf("regAddr[%0d]", idx), word.regAddr, expTable[idx][15:8]);
		checkValue($sformatf("regData[%0d]", idx), word.regData, expTable[idx][7:0]);
	endtask

	// Reset mid-run, bus must be idle throughout
	task automatic applyReset();
		@(posedge iCLK);
		#1 resetReq = 1'b1;
		repeat (ResetCycles)
		begin
			@(negedge iCLK);
			expectBusIdle();
		end
		@(posedge iCLK);
		#1 resetReq = 1'b0;
		// Writes seen before the reset no longer count
		writeQ.delete();
	endtask

	// ----------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------
	task automatic idleDuringReset();
		int cycles;
		cycles = 0;
		@(negedge iCLK);
		while (!iRST_N && cycles < 10 * ResetCycles)
		begin
			expectBusIdle();
			@(negedge iCLK);
			cycles++;
		end
		if (!iRST_N)
			reportError("reset was never released");
		else
		begin
			// First cycle after release and the one after it
			expectBusIdle();
			@(negedge iCLK);
			expectBusIdle();
		end
	endtask

	task automatic firstWriteBytes();
		sccbFieldsT word;
		bit ok;
		waitWrite(word, ok);
		if (ok)
		begin
			checkValue("devAddr[0]", word.devAddr, 8'h42);
			checkValue("regAddr[0]", word.regAddr, 8'h12);
			checkValue("regData[0]", word.regData, 8'h80);
		end
	endtask

	task automatic writesInTableOrder();
		sccbFieldsT word;
		bit ok;
		ok = 1'b1;
		for (int i = 1; i < 40 && ok; i++)
		begin
			waitWrite(word, ok);
			if (ok)
				compareWrite(i, word);
		end
		checkValue("startCount", startCount, 40);
		checkValue("stopCount", stopCount, 40);
		// Bus free period still running
		@(negedge iCLK);
		checkValue("configDone", configDone, 0);
	endtask

	task automatic quietAfterDone();
		int cycles;
		int startsBefore;
		logic stayedHigh;
		cycles = 0;
		while (!configDone && cycles < DoneTimeout)
		begin
			@(negedge iCLK);
			cycles++;
		end
		if (!configDone)
			reportError("configDone never rose after the last write");
		else
		begin
			startsBefore = startCount;
			stayedHigh   = 1'b1;
			for (cycles = 0; cycles < QuietCycles; cycles++)
			begin
				@(negedge iCLK);
				stayedHigh = stayedHigh & configDone;
			end
			checkValue("configDone", stayedHigh, 1);
			checkValue("startCount", startCount, startsBefore);
		end
	endtask

	task automatic restartAfterReset();
		sccbFieldsT word;
		bit ok;
		// Restart and get partway into the table
		applyReset();
		waitWrite(word, ok);
		if (ok)
			compareWrite(0, word);
		waitWrite(word, ok);
		if (ok)
			compareWrite(1, word);
		// Queue only moves on falling edges
		repeat (MidWriteCycles) @(posedge iCLK);
		checkValue("pendingWrites", writeQ.size(), 0);
		// Cut the third write short
		applyReset();
		for (int i = 0; i < 3 && ok; i++)
		begin
			waitWrite(word, ok);
			if (ok)
				compareWrite(i, word);
		end
	endtask

	// ----------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------
	initial
	begin
		resetReq   = 1'b0;
		errors     = 0;
		checks     = 0;
		prevSioc   = 1'b1;
		prevSda    = 1'b1;
		inFrame    = 1'b0;
		measuring  = 1'b0;
		bitCnt     = 0;
		highCnt    = 0;
		startCount = 0;
		stopCount  = 0;
		frameBits  = '0;
		// Sensor settings in send order
		expTable = '{
			16'h1280, 16'h1101, 16'h9200, 16'h9300, 16'h2a00,
			16'h2b00, 16'h3b0a, 16'h3a00, 16'h3dc2, 16'h40d0,
			16'h1200, 16'h1713, 16'h1801, 16'h32b6, 16'h1902,
			16'h1a7a, 16'h030a, 16'h0c00, 16'h3e00, 16'h703a,
			16'h7135, 16'h7211, 16'h73f0, 16'ha202, 16'h7a20,
			16'h7b10, 16'h7c1e, 16'h7d35, 16'h7e5a, 16'h7f69,
			16'h8076, 16'h8180, 16'h8288, 16'h838f, 16'h8496,
			16'h85a3, 16'h86af, 16'h87c4, 16'h88d7, 16'h89e8
		};

		idleDuringReset();
		firstWriteBytes();
		writesInTableOrder();
		quietAfterDone();
		restartAfterReset();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== camConfigTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module camConfigTop (
	input  logic iCLK,
	input  logic iRST_N,
	output logic sioc,
	output logic siodOut,
	output logic siodOe,
	output logic configDone
);

	import camConfigPkg::*;

	// Table lookup
	tableIndexT entryIndex;
	regEntryT   entry;

	// Sequencer to write master
	sccbFrameT  frame;
	logic       go;
	logic       done;

	// ----------------------------------------------------------
	// Sensor settings
	// ----------------------------------------------------------
	camRegTable uRegTable (
		.entryIndex (entryIndex),
		.entry      (entry)
	);

	// One write per entry
	camConfigSequencer uSequencer (
		.iCLK       (iCLK),
		.iRST_N     (iRST_N),
		.entryIndex (entryIndex),
		.entry      (entry),
		.frame      (frame),
		.go         (go),
		.done       (done),
		.configDone (configDone)
	);

	// SCCB pins, board adds the open drain buffer
	sccbWriteMaster uWriteMaster (
		.iCLK    (iCLK),
		.iRST_N  (iRST_N),
		.frame   (frame),
		.go      (go),
		.done    (done),
		.sioc    (sioc),
		.siodOut (siodOut),
		.siodOe  (siodOe)
	);

endmodule

`default_nettype wire

// ==== camRegTable.sv ====
`timescale 1ns/100ps
`default_nettype none

module camRegTable (
	input  camConfigPkg::tableIndexT entryIndex,
	output camConfigPkg::regEntryT   entry
);

	// Purely combinational lookup
	// upper byte register address, lower byte value
	always_comb
	begin
		case (entryIndex)
			// ----------------------------------------------------------
			// Reset and clocking
			// ----------------------------------------------------------
			// COM7 soft reset of every register
			6'd0:  entry = 16'h1280;
			// CLKRC prescaler
			6'd1:  entry = 16'h1101;
			// Dummy lines
			6'd2:  entry = 16'h9200;
			6'd3:  entry = 16'h9300;
			// Dummy pixels
			6'd4:  entry = 16'h2a00;
			6'd5:  entry = 16'h2b00;
			// COM11 night mode and banding
			6'd6:  entry = 16'h3b0a;

			// ----------------------------------------------------------
			// Output format
			// ----------------------------------------------------------
			// TSLB byte order
			6'd7:  entry = 16'h3a00;
			// COM13 gamma and UV
			6'd8:  entry = 16'h3dc2;
			// COM15 full output range
			6'd9:  entry = 16'h40d0;
			// COM7 back to YUV
			6'd10: entry = 16'h1200;

			// ----------------------------------------------------------
			// Window
			// ----------------------------------------------------------
			// Horizontal start and stop
			6'd11: entry = 16'h1713;
			6'd12: entry = 16'h1801;
			// HREF low bits
			6'd13: entry = 16'h32b6;
			// Vertical start and stop
			6'd14: entry = 16'h1902;
			6'd15: entry = 16'h1a7a;
			// VREF low bits
			6'd16: entry = 16'h030a;

			// Scaling and downsampling
			6'd17: entry = 16'h0c00;
			6'd18: entry = 16'h3e00;
			6'd19: entry = 16'h703a;
			6'd20: entry = 16'h7135;
			6'd21: entry = 16'h7211;
			6'd22: entry = 16'h73f0;
			// Scaled PCLK delay
			6'd23: entry = 16'ha202;

			// ----------------------------------------------------------
			// Gamma curve
			// ----------------------------------------------------------
			// Slope of the last segment
			6'd24: entry = 16'h7a20;
			// GAM1 to GAM15
			6'd25: entry = 16'h7b10;
			6'd26: entry = 16'h7c1e;
			6'd27: entry = 16'h7d35;
			6'd28: entry = 16'h7e5a;
			6'd29: entry = 16'h7f69;
			6'd30: entry = 16'h8076;
			6'd31: entry = 16'h8180;
			6'd32: entry = 16'h8288;
			6'd33: entry = 16'h838f;
			6'd34: entry = 16'h8496;
			6'd35: entry = 16'h85a3;
			6'd36: entry = 16'h86af;
			6'd37: entry = 16'h87c4;
			6'd38: entry = 16'h88d7;
			6'd39: entry = 16'h89e8;
			// Past the end of the table
			default: entry = 16'hffff;
		endcase
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module camConfigTb -f sim.f -o simv \
	&& ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '^\*\* PASS \*\*$' sim.log 2>/dev/null && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== sccbWriteMaster.sv ====
`timescale 1ns/100ps
`default_nettype none

module sccbWriteMaster (
	input  logic                    iCLK,
	input  logic                    iRST_N,
	input  camConfigPkg::sccbFrameT frame,
	input  logic                    go,
	output logic                    done,
	output logic                    sioc,
	output logic                    siodOut,
	output logic                    siodOe
);

	import camConfigPkg::*;

	typedef enum logic [2:0] {
		PhIdle,
		PhStart,
		PhBits,
		PhStop,
		PhFree
	} phaseT;

	// Pin levels kept as one register
	typedef struct packed {
		logic sioc;
		logic siodOut;
		logic siodOe;
	} busPinsT;

	phaseT               phase;
	logic [1:0]          qtr;
	logic [3:0]          bitNum;
	logic [1:0]          byteIdx;
	logic [DivWidth-1:0] divCnt;
	busPinsT             pins;
	logic                tick;

	// Position after the coming tick
	phaseT               nxtPhase;
	logic [1:0]          nxtQtr;
	logic [3:0]          nxtBit;
	logic [1:0]          nxtByte;
	logic                nxtData;
	logic                nxtNinth;

	// ----------------------------------------------------------
	// Bus levels for one quarter
	// ----------------------------------------------------------
	// Quarter 0 of a bit only drops SIOC, data follows in quarter 1
	function automatic busPinsT pinLevels(
		input phaseT      ph,
		input logic [1:0] q,
		input logic       dataBit,
		input logic       ninth,
		input busPinsT    prev
	);
		busPinsT p;
		p = prev;
		case (ph)
			// SIOD falls halfway with SIOC held high
			PhStart:
			begin
				p.sioc    = 1'b1;
				p.siodOe  = 1'b1;
				p.siodOut = ~q[1];
			end
			PhBits:
			begin
				p.sioc = q[1];
				if (q == 2'd1)
				begin
					// Ninth bit is don't care, let go of the line
					p.siodOut = ninth | dataBit;
					p.siodOe  = ~ninth;
				end
			end
			// Pull SIOD low, raise SIOC, then release SIOD
			PhStop:
			begin
				p.sioc = q[1];
				if (q == 2'd1)
				begin
					p.siodOut = 1'b0;
					p.siodOe  = 1'b1;
				end
				else if (q == 2'd3)
					p.siodOut = 1'b1;
			end
			// Idle and bus free look the same
			default:
			begin
				p.sioc    = 1'b1;
				p.siodOut = 1'b1;
				p.siodOe  = 1'b0;
			end
		endcase
		return p;
	endfunction

	// Divider only counts during a write
	assign tick = (phase != PhIdle) && (divCnt == DivWidth'(QuarterDiv - 1));

	// ----------------------------------------------------------
	// Next position in the frame
	// ----------------------------------------------------------
	always_comb
	begin
		nxtPhase = phase;
		nxtQtr   = qtr + 2'd1;
		nxtBit   = bitNum;
		nxtByte  = byteIdx;
		if (qtr == 2'd3)
		begin
			case (phase)
				PhStart:
				begin
					nxtPhase = PhBits;
					nxtBit   = 4'd0;
					nxtByte  = 2'd2;
				end
				PhBits:
				begin
					if (bitNum == 4'd8)
					begin
						nxtBit = 4'd0;
						// Last byte done, go to stop
						if (byteIdx == 2'd0)
							nxtPhase = PhStop;
						else
							nxtByte = byteIdx - 2'd1;
					end
					else
						nxtBit = bitNum + 4'd1;
				end
				PhStop:
					nxtPhase = PhFree;
				PhFree:
					nxtPhase = PhIdle;
				default:
					nxtPhase = PhIdle;
			endcase
		end
	end

	// MSB first through the byte view
	assign nxtData  = frame.bytes[nxtByte][~nxtBit[2:0]];
	assign nxtNinth = (nxtBit == 4'd8);

	// ----------------------------------------------------------
	// Sequencing and pins
	// ----------------------------------------------------------
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			phase   <= PhIdle;
			qtr     <= 2'd0;
			bitNum  <= 4'd0;
			byteIdx <= 2'd0;
			divCnt  <= '0;
			pins    <= '{sioc: 1'b1, siodOut: 1'b1, siodOe: 1'b0};
			done    <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (go && phase == PhIdle)
			begin
				// Ticks aligned to go
				phase  <= PhStart;
				qtr    <= 2'd0;
				divCnt <= '0;
				pins   <= pinLevels(PhStart, 2'd0, 1'b1, 1'b0, pins);
			end
			else if (tick)
			begin
				divCnt  <= '0;
				phase   <= nxtPhase;
				qtr     <= nxtQtr;
				bitNum  <= nxtBit;
				byteIdx <= nxtByte;
				pins    <= pinLevels(nxtPhase, nxtQtr, nxtData, nxtNinth, pins);
				// End of the bus free period
				if (phase == PhFree && qtr == 2'd3)
					done <= 1'b1;
			end
			else if (phase != PhIdle)
				divCnt <= divCnt + 1'b1;
		end
	end

	assign sioc    = pins.sioc;
	assign siodOut = pins.siodOut;
	assign siodOe  = pins.siodOe;

	goOnlyIdle: assert property (@(posedge iCLK) disable iff (!iRST_N)
		go |-> phase == PhIdle);

	// Data moves under a high clock only for start and stop
	siodStableHigh: assert property (@(posedge iCLK) disable iff (!iRST_N)
		(sioc && $past(sioc) && $changed(siodOut))
			|-> (phase == PhStart || phase == PhStop));

endmodule

`default_nettype wire

// ==== sim.f ====
camConfigPkg.sv
camRegTable.sv
camConfigSequencer.sv
sccbWriteMaster.sv
camConfigTop.sv
tbClockGen.sv
camConfigTb.sv

// ==== tbClockGen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbClockGen (
	input  logic resetReq,
	output logic iCLK,
	output logic iRST_N
);

	// 25 MHz testbench clock
	localparam int ClkPeriod   = 40;
	localparam int ResetCycles = 16;

	logic powerOnDone;

	initial
	begin
		iCLK = 1'b0;
		forever #(ClkPeriod / 2) iCLK = ~iCLK;
	end

	// Power-on reset, released just after a rising edge
	initial
	begin
		powerOnDone = 1'b0;
		repeat (ResetCycles) @(posedge iCLK);
		#1 powerOnDone = 1'b1;
	end

	// Extra resets requested by the testbench
	assign iRST_N = powerOnDone && !resetReq;

endmodule

`default_nettype wire
